//--- project.f
+incdir+tb
src/decode_pkg.sv
src/id_pipe_reg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_forward.sv
src/branch_unit.sv
src/id_stage.sv
tb/id_stage_tb.sv

//--- src/branch_unit.sv
module branch_unit (
    input  logic                     ds_valid,
    input  decode_pkg::decode_ctrl_t ctrl,
    input  decode_pkg::word_t        inst,
    input  decode_pkg::word_t        pc,
    input  decode_pkg::word_t        rs_value,
    input  decode_pkg::word_t        rt_value,
    input  logic                     load_stall,
    output decode_pkg::branch_bus_t  br_bus
);
    import decode_pkg::*;

    word_t seq_pc;      // delay slot address
    word_t br_offset;
    word_t target;
    logic  rs_eq_rt;
    logic  rs_neg;
    logic  cond;
    logic  taken;

    assign seq_pc    = pc + 32'd4;
    assign br_offset = {{14{ctrl.imm[15]}}, ctrl.imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_neg    = rs_value[31];

    always_comb begin
        case (ctrl.branch_kind)
            br_beq:              cond = rs_eq_rt;
            br_bne:              cond = !rs_eq_rt;
            br_bgez:             cond = !rs_neg;
            br_bltz:             cond = rs_neg;
            br_j, br_jal, br_jr: cond = 1'b1;
            default:             cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.branch_kind)
            br_beq, br_bne, br_bgez, br_bltz: target = seq_pc + br_offset;
            br_j, br_jal: target = {seq_pc[31:28], inst[25:0], 2'b00};  // 256 MB region
            br_jr:        target = rs_value;
            default:      target = seq_pc;
        endcase
    end

    assign taken  = ds_valid && cond;
    // fetch must not redirect on stale operands
    assign br_bus = '{stall: load_stall && taken, taken: taken, target: target};

endmodule

//--- src/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t reg_zero = 5'd0;
    localparam reg_addr_t link_reg = 5'd31;   // jal destination

    // rt field values that pick the regimm branch
    localparam reg_addr_t rt_bltz = 5'h00;
    localparam reg_addr_t rt_bgez = 5'h01;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } fetch_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_write_t;

    // one later stage as seen by decode, dest 0 when it writes nothing
    typedef struct packed {
        reg_addr_t dest;
        word_t     result;
    } fwd_src_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src2_reg, src2_imm_zero, src2_imm_sign
    } src2_sel_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_bgez, br_bltz, br_j, br_jal, br_jr
    } branch_kind_e;

    typedef enum logic [5:0] {
        op_special = 6'h00, op_regimm = 6'h01, op_j     = 6'h02, op_jal   = 6'h03,
        op_beq     = 6'h04, op_bne    = 6'h05, op_addi  = 6'h08, op_addiu = 6'h09,
        op_slti    = 6'h0a, op_sltiu  = 6'h0b, op_andi  = 6'h0c, op_ori   = 6'h0d,
        op_xori    = 6'h0e, op_lui    = 6'h0f, op_lw    = 6'h23, op_sw    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll = 6'h00, fn_srl  = 6'h02, fn_sra = 6'h03, fn_jr  = 6'h08,
        fn_addu = 6'h21, fn_subu = 6'h23, fn_and = 6'h24, fn_or  = 6'h25,
        fn_xor = 6'h26, fn_nor  = 6'h27, fn_slt = 6'h2a, fn_sltu = 6'h2b
    } funct_e;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         src1_is_sa;
        logic         src1_is_pc;
        src2_sel_e    src2_sel;
        logic         src2_is_8;    // link value pc + 8
        logic         gr_we;
        logic         mem_we;
        logic         load_op;
        reg_addr_t    dest;
        logic [15:0]  imm;
        logic         reads_rs;
        logic         reads_rt;
        branch_kind_e branch_kind;
    } decode_ctrl_t;

    localparam decode_ctrl_t ctrl_nop = '{
        alu_op: alu_add, src1_is_sa: 1'b0, src1_is_pc: 1'b0, src2_sel: src2_reg,
        src2_is_8: 1'b0, gr_we: 1'b0, mem_we: 1'b0, load_op: 1'b0,
        dest: reg_zero, imm: 16'h0000, reads_rs: 1'b0, reads_rt: 1'b0,
        branch_kind: br_none
    };

    typedef struct packed {
        decode_ctrl_t ctrl;
        word_t        rs_value;
        word_t        rt_value;
        word_t        pc;
    } issue_bus_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        word_t target;
    } branch_bus_t;

endpackage

//--- src/id_pipe_reg.sv
module id_pipe_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   fs_to_ds_valid,
    input  logic                   ds_allowin,
    input  decode_pkg::fetch_bus_t fs_to_ds_bus,
    output logic                   ds_valid,
    output decode_pkg::fetch_bus_t ds_bus
);
    import decode_pkg::*;

    logic accept;

    // fetch hands over an instruction this edge
    assign accept = fs_to_ds_valid && ds_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;            // flush wins over a load
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;  // empties when fetch has nothing
        end
    end

    // instruction and pc, only loaded on a real transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

endmodule

//--- src/id_stage.sv
module id_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    fs_to_ds_valid,
    input  decode_pkg::fetch_bus_t  fs_to_ds_bus,
    output logic                    ds_allowin,
    input  logic                    es_allowin,
    output logic                    ds_to_es_valid,
    output decode_pkg::issue_bus_t  ds_to_es_bus,
    output decode_pkg::branch_bus_t br_bus,
    input  decode_pkg::wb_write_t   ws_to_rf_bus,
    input  decode_pkg::fwd_src_t    exe_fwd,
    input  decode_pkg::fwd_src_t    mem_fwd,
    input  decode_pkg::fwd_src_t    wb_fwd,
    input  logic                    es_load_op
);
    import decode_pkg::*;

    logic         ds_valid;
    fetch_bus_t   ds_bus;
    decode_ctrl_t ctrl;
    reg_addr_t    rs;
    reg_addr_t    rt;
    word_t        rf_rs;
    word_t        rf_rt;
    word_t        rs_value;
    word_t        rt_value;
    logic         load_stall;
    logic         ds_ready_go;

    assign rs = ds_bus.inst[25:21];
    assign rt = ds_bus.inst[20:16];

    // handshake with fetch and execute
    assign ds_ready_go    = !load_stall;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    id_pipe_reg u_pipe_reg (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_valid       (ds_valid),
        .ds_bus         (ds_bus)
    );

    inst_decoder u_decoder (
        .inst (ds_bus.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .wr     (ws_to_rf_bus),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt)
    );

    operand_forward u_forward (
        .ds_valid   (ds_valid),
        .ctrl       (ctrl),
        .rs         (rs),
        .rt         (rt),
        .rf_rs      (rf_rs),
        .rf_rt      (rf_rt),
        .exe_fwd    (exe_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .es_load_op (es_load_op),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall)
    );

    branch_unit u_branch (
        .ds_valid   (ds_valid),
        .ctrl       (ctrl),
        .inst       (ds_bus.inst),
        .pc         (ds_bus.pc),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .load_stall (load_stall),
        .br_bus     (br_bus)
    );

    assign ds_to_es_bus = '{ctrl: ctrl, rs_value: rs_value, rt_value: rt_value,
                            pc: ds_bus.pc};

endmodule

//--- src/inst_decoder.sv
module inst_decoder (
    input  decode_pkg::word_t        inst,
    output decode_pkg::decode_ctrl_t ctrl
);
    import decode_pkg::*;

    opcode_e     op;
    funct_e      funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm;

    assign op    = opcode_e'(inst[31:26]);
    assign funct = funct_e'(inst[5:0]);
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign imm   = inst[15:0];

    // rd <= rs op rt
    function automatic decode_ctrl_t reg_op(alu_op_e alu, reg_addr_t dst);
        decode_ctrl_t c;
        c          = ctrl_nop;
        c.alu_op   = alu;
        c.gr_we    = 1'b1;
        c.dest     = dst;
        c.reads_rs = 1'b1;
        c.reads_rt = 1'b1;
        return c;
    endfunction

    // rd <= rt shifted by sa, rs not read
    function automatic decode_ctrl_t shift_op(alu_op_e alu, reg_addr_t dst);
        decode_ctrl_t c;
        c            = reg_op(alu, dst);
        c.src1_is_sa = 1'b1;
        c.reads_rs   = 1'b0;
        return c;
    endfunction

    // rt <= rs op imm
    function automatic decode_ctrl_t imm_op(alu_op_e alu, src2_sel_e sel, reg_addr_t dst);
        decode_ctrl_t c;
        c          = ctrl_nop;
        c.alu_op   = alu;
        c.src2_sel = sel;
        c.gr_we    = 1'b1;
        c.dest     = dst;
        c.reads_rs = 1'b1;
        return c;
    endfunction

    always_comb begin
        ctrl = ctrl_nop;
        case (op)
            op_special: begin
                case (funct)
                    fn_addu: if (sa == 5'd0) ctrl = reg_op(alu_add, rd);
                    fn_subu: if (sa == 5'd0) ctrl = reg_op(alu_sub, rd);
                    fn_slt:  if (sa == 5'd0) ctrl = reg_op(alu_slt, rd);
                    fn_sltu: if (sa == 5'd0) ctrl = reg_op(alu_sltu, rd);
                    fn_and:  if (sa == 5'd0) ctrl = reg_op(alu_and, rd);
                    fn_or:   if (sa == 5'd0) ctrl = reg_op(alu_or, rd);
                    fn_xor:  if (sa == 5'd0) ctrl = reg_op(alu_xor, rd);
                    fn_nor:  if (sa == 5'd0) ctrl = reg_op(alu_nor, rd);
                    fn_sll:  if (rs == reg_zero) ctrl = shift_op(alu_sll, rd);
                    fn_srl:  if (rs == reg_zero) ctrl = shift_op(alu_srl, rd);
                    fn_sra:  if (rs == reg_zero) ctrl = shift_op(alu_sra, rd);
                    fn_jr: begin
                        if (rt == reg_zero && rd == reg_zero && sa == 5'd0) begin
                            ctrl.reads_rs    = 1'b1;
                            ctrl.branch_kind = br_jr;
                        end
                    end
                    default: ;
                endcase
            end
            op_regimm: begin
                if (rt == rt_bgez || rt == rt_bltz) begin
                    ctrl.reads_rs    = 1'b1;
                    ctrl.branch_kind = (rt == rt_bgez) ? br_bgez : br_bltz;
                end
            end
            op_addiu, op_addi: ctrl = imm_op(alu_add, src2_imm_sign, rt);  // no overflow trap
            op_slti:  ctrl = imm_op(alu_slt, src2_imm_sign, rt);
            op_sltiu: ctrl = imm_op(alu_sltu, src2_imm_sign, rt);
            op_andi:  ctrl = imm_op(alu_and, src2_imm_zero, rt);
            op_ori:   ctrl = imm_op(alu_or, src2_imm_zero, rt);
            op_xori:  ctrl = imm_op(alu_xor, src2_imm_zero, rt);
            op_lui: begin
                if (rs == reg_zero) begin
                    ctrl          = imm_op(alu_lui, src2_imm_zero, rt);
                    ctrl.reads_rs = 1'b0;
                end
            end
            op_lw: begin
                ctrl         = imm_op(alu_add, src2_imm_sign, rt);
                ctrl.load_op = 1'b1;
            end
            op_sw: begin
                ctrl          = imm_op(alu_add, src2_imm_sign, reg_zero);
                ctrl.gr_we    = 1'b0;
                ctrl.mem_we   = 1'b1;
                ctrl.reads_rt = 1'b1;   // store data
            end
            op_beq, op_bne: begin
                ctrl.reads_rs    = 1'b1;
                ctrl.reads_rt    = 1'b1;
                ctrl.branch_kind = (op == op_beq) ? br_beq : br_bne;
            end
            op_j: ctrl.branch_kind = br_j;
            op_jal: begin
                ctrl.src1_is_pc  = 1'b1;
                ctrl.src2_is_8   = 1'b1;
                ctrl.gr_we       = 1'b1;
                ctrl.dest        = link_reg;
                ctrl.branch_kind = br_jal;
            end
            default: ;
        endcase
        ctrl.imm = imm;  // raw field, each consumer extends it
    end

endmodule

//--- src/operand_forward.sv
module operand_forward (
    input  logic                     ds_valid,
    input  decode_pkg::decode_ctrl_t ctrl,
    input  decode_pkg::reg_addr_t    rs,
    input  decode_pkg::reg_addr_t    rt,
    input  decode_pkg::word_t        rf_rs,
    input  decode_pkg::word_t        rf_rt,
    input  decode_pkg::fwd_src_t     exe_fwd,
    input  decode_pkg::fwd_src_t     mem_fwd,
    input  decode_pkg::fwd_src_t     wb_fwd,
    input  logic                     es_load_op,
    output decode_pkg::word_t        rs_value,
    output decode_pkg::word_t        rt_value,
    output logic                     load_stall
);
    import decode_pkg::*;

    logic exe_rs;
    logic exe_rt;

    // source really read, not r0, and written by that stage
    function automatic logic hit(logic used, reg_addr_t src, fwd_src_t stage);
        return used && (src != reg_zero) && (src == stage.dest);
    endfunction

    // youngest producer first
    function automatic word_t pick(logic used, reg_addr_t src, word_t rf_val,
                                   fwd_src_t exe, fwd_src_t mem, fwd_src_t wb);
        word_t v;
        if (hit(used, src, exe)) begin
            v = exe.result;
        end else if (hit(used, src, mem)) begin
            v = mem.result;
        end else if (hit(used, src, wb)) begin
            v = wb.result;   // covers the regfile write in this cycle
        end else begin
            v = rf_val;
        end
        return v;
    endfunction

    assign rs_value = pick(ctrl.reads_rs, rs, rf_rs, exe_fwd, mem_fwd, wb_fwd);
    assign rt_value = pick(ctrl.reads_rt, rt, rf_rt, exe_fwd, mem_fwd, wb_fwd);

    assign exe_rs = hit(ctrl.reads_rs, rs, exe_fwd);
    assign exe_rt = hit(ctrl.reads_rt, rt, exe_fwd);

    // load data not ready before MEM
    assign load_stall = ds_valid && es_load_op && (exe_rs || exe_rt);

endmodule

//--- src/regfile.sv
module regfile (
    input  logic                  clk,
    input  decode_pkg::wb_write_t wr,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);
    import decode_pkg::*;

    word_t rf [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != reg_zero) begin
            rf[wr.addr] <= wr.data;
        end
    end

    // asynchronous reads, old value during the write cycle
    assign rdata1 = (raddr1 == reg_zero) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == reg_zero) ? '0 : rf[raddr2];

endmodule

//--- tb/id_ref_model.svh
`ifndef id_ref_model_svh
`define id_ref_model_svh

// reference copy of the stage register and the register file
logic       m_valid;
fetch_bus_t m_bus;
word_t      m_rf [32];

// all-zero control fields mean no-op
function automatic decode_ctrl_t model_decode(input word_t inst);
    decode_ctrl_t c;
    alu_op_e      r_op;
    alu_op_e      i_op;
    logic         r_ok;
    logic [5:0]   op;
    logic [5:0]   fn;
    op    = inst[31:26];
    fn    = inst[5:0];
    c     = '0;
    c.imm = inst[15:0];
    r_op  = alu_add;
    r_ok  = 1'b1;
    case (fn)
        6'h00: r_op = alu_sll;
        6'h02: r_op = alu_srl;
        6'h03: r_op = alu_sra;
        6'h21: r_op = alu_add;
        6'h23: r_op = alu_sub;
        6'h24: r_op = alu_and;
        6'h25: r_op = alu_or;
        6'h26: r_op = alu_xor;
        6'h27: r_op = alu_nor;
        6'h2a: r_op = alu_slt;
        6'h2b: r_op = alu_sltu;
        default: r_ok = 1'b0;
    endcase
    case (op[2:0])
        3'd2: i_op = alu_slt;
        3'd3: i_op = alu_sltu;
        3'd4: i_op = alu_and;
        3'd5: i_op = alu_or;
        3'd6: i_op = alu_xor;
        3'd7: i_op = alu_lui;
        default: i_op = alu_add;   // addi and addiu
    endcase
    // shifts need rs zero, the rest need sa zero
    if (op == 6'h00 && r_ok && (fn[5] ? inst[10:6] == 5'd0 : inst[25:21] == 5'd0)) begin
        c.alu_op     = r_op;
        c.gr_we      = 1'b1;
        c.dest       = inst[15:11];
        c.reads_rs   = fn[5];
        c.reads_rt   = 1'b1;
        c.src1_is_sa = !fn[5];
    end
    if (op[5:3] == 3'b001 && (op != 6'h0f || inst[25:21] == 5'd0)) begin
        c.alu_op   = i_op;
        c.gr_we    = 1'b1;
        c.dest     = inst[20:16];
        c.reads_rs = (op != 6'h0f);
        c.src2_sel = op[2] ? src2_imm_zero : src2_imm_sign;
    end
    if (op == 6'h23 || op == 6'h2b) begin   // lw, sw
        c.src2_sel = src2_imm_sign;
        c.reads_rs = 1'b1;
        c.reads_rt = op[3];
        c.gr_we    = !op[3];
        c.load_op  = !op[3];
        c.mem_we   = op[3];
        c.dest     = op[3] ? 5'd0 : inst[20:16];
    end
    case (op)
        6'h00: begin
            if (fn == 6'h08 && inst[20:6] == 15'd0) begin
                c.reads_rs    = 1'b1;
                c.branch_kind = br_jr;
            end
        end
        6'h01: begin
            if (inst[20:17] == 4'd0) begin
                c.reads_rs    = 1'b1;
                c.branch_kind = inst[16] ? br_bgez : br_bltz;
            end
        end
        6'h02: c.branch_kind = br_j;
        6'h03: begin
            c.branch_kind = br_jal;
            c.gr_we       = 1'b1;
            c.dest        = 5'd31;
            c.src1_is_pc  = 1'b1;
            c.src2_is_8   = 1'b1;
        end
        6'h04, 6'h05: begin
            c.reads_rs    = 1'b1;
            c.reads_rt    = 1'b1;
            c.branch_kind = op[0] ? br_bne : br_beq;
        end
        default: ;
    endcase
    return c;
endfunction

function automatic logic fwd_hit(input logic used, input reg_addr_t r, input fwd_src_t s);
    return used && r != 5'd0 && r == s.dest;
endfunction

// EXE first, then MEM, then WB, then the register file
function automatic word_t model_operand(input logic used, input reg_addr_t r);
    if (fwd_hit(used, r, exe_fwd))
        return exe_fwd.result;
    if (fwd_hit(used, r, mem_fwd))
        return mem_fwd.result;
    if (fwd_hit(used, r, wb_fwd))
        return wb_fwd.result;
    return m_rf[r];
endfunction

function automatic branch_bus_t model_branch(input decode_ctrl_t c, input fetch_bus_t b,
                                             input word_t rsv, input word_t rtv);
    branch_bus_t r;
    word_t       seq;
    seq      = b.pc + 32'd4;
    r.stall  = 1'b0;
    r.taken  = 1'b1;
    r.target = seq + {{14{b.inst[15]}}, b.inst[15:0], 2'b00};
    case (c.branch_kind)
        br_beq:       r.taken = (rsv == rtv);
        br_bne:       r.taken = (rsv != rtv);
        br_bgez:      r.taken = !rsv[31];
        br_bltz:      r.taken = rsv[31];
        br_jr:        r.target = rsv;
        br_j, br_jal: r.target = {seq[31:28], b.inst[25:0], 2'b00};
        default:      r.taken = 1'b0;
    endcase
    r.taken = r.taken && m_valid;
    return r;
endfunction

// state as it stands after the coming clock edge
task automatic model_step(input logic allowin);
    if (ws_to_rf_bus.we && ws_to_rf_bus.addr != 5'd0)
        m_rf[ws_to_rf_bus.addr] = ws_to_rf_bus.data;
    if (allowin && fs_to_ds_valid && !flush)
        m_bus = fs_to_ds_bus;
    if (reset || flush)
        m_valid = 1'b0;
    else if (allowin)
        m_valid = fs_to_ds_valid;
endtask

`endif

//--- tb/id_stage_tb.sv
module id_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    localparam int run_len      = 300;
    localparam int total_cycles = 4 + 32 + 5 * run_len;

    logic        clk;
    logic        reset;
    logic        flush;
    logic        fs_to_ds_valid;
    fetch_bus_t  fs_to_ds_bus;
    logic        ds_allowin;
    logic        es_allowin;
    logic        ds_to_es_valid;
    issue_bus_t  ds_to_es_bus;
    branch_bus_t br_bus;
    wb_write_t   ws_to_rf_bus;
    fwd_src_t    exe_fwd;
    fwd_src_t    mem_fwd;
    fwd_src_t    wb_fwd;
    logic        es_load_op;

    // stimulus mix of the running test, in percent
    int          fetch_pct;
    int          hold_pct;
    int          flush_pct;
    int          load_pct;
    logic        fwd_on;
    logic        branch_only;
    reg_addr_t   reg_mask;
    int          checks;
    int          errors;
    int          test_errors;
    int          failed_tests;

    `include "id_ref_model.svh"

    id_stage dut (.*);

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_cycle();
        decode_ctrl_t c;
        branch_bus_t  br;
        word_t        rsv;
        word_t        rtv;
        logic         stall;
        logic         allowin;
        c        = model_decode(m_bus.inst);
        rsv      = model_operand(c.reads_rs, m_bus.inst[25:21]);
        rtv      = model_operand(c.reads_rt, m_bus.inst[20:16]);
        stall    = m_valid && es_load_op && (fwd_hit(c.reads_rs, m_bus.inst[25:21], exe_fwd)
                   || fwd_hit(c.reads_rt, m_bus.inst[20:16], exe_fwd));
        br       = model_branch(c, m_bus, rsv, rtv);
        br.stall = stall && br.taken;
        allowin  = !m_valid || (!stall && es_allowin);
        check_value("ds_allowin", ds_allowin, allowin);
        check_value("ds_to_es_valid", ds_to_es_valid, m_valid && !stall);
        check_value("br_bus.taken", br_bus.taken, br.taken);
        check_value("br_bus.stall", br_bus.stall, br.stall);
        if (m_valid) begin
            check_value("ds_to_es_bus.ctrl", ds_to_es_bus.ctrl, c);
            check_value("ds_to_es_bus.rs_value", ds_to_es_bus.rs_value, rsv);
            check_value("ds_to_es_bus.rt_value", ds_to_es_bus.rt_value, rtv);
            check_value("ds_to_es_bus.pc", ds_to_es_bus.pc, m_bus.pc);
        end
        if (br.taken)
            check_value("br_bus.target", br_bus.target, br.target);
        model_step(allowin);
    endtask

    function automatic reg_addr_t reg_pick();
        return reg_addr_t'($urandom & reg_mask);
    endfunction

    // kept subset plus raw words, most of which decode as no-op
    function automatic word_t random_inst();
        word_t w;
        int    kind;
        w        = $urandom;
        w[25:21] = w[25:21] & reg_mask;
        w[20:16] = w[20:16] & reg_mask;
        w[15:11] = w[15:11] & reg_mask;
        kind     = branch_only ? $urandom_range(6) : $urandom_range(14);
        case (kind)
            0: w[31:26] = 6'h04;                               // beq
            1: w[31:26] = 6'h05;                               // bne
            2: w = {6'h01, w[25:21], 4'h0, w[16:0]};           // bgez, bltz
            3: w[31:26] = 6'h02;                               // j
            4: w[31:26] = 6'h03;                               // jal
            5: w = {6'h00, w[25:21], 15'h0000, 6'h08};         // jr
            7: w = {6'h00, w[25:11], 5'd0, 6'h20 + 6'($urandom_range(11))};
            8: w = {6'h00, 5'd0, w[20:6], 6'($urandom_range(3))};
            9: w[31:26] = 6'h08 + 6'($urandom_range(7));
            10: w[31:26] = 6'h23;                              // lw
            11: w[31:26] = 6'h2b;                              // sw
            12: w = {6'h0f, 5'd0, w[20:0]};                    // lui
            default: ;
        endcase
        return w;
    endfunction

    task automatic drive_random();
        word_t pc;
        pc                = $urandom;
        fs_to_ds_valid    = ($urandom_range(99) < fetch_pct);
        fs_to_ds_bus.inst = random_inst();
        fs_to_ds_bus.pc   = {pc[31:2], 2'b00};
        es_allowin        = ($urandom_range(99) >= hold_pct);
        flush             = ($urandom_range(99) < flush_pct);
        es_load_op        = ($urandom_range(99) < load_pct);
        exe_fwd           = '{dest: fwd_on ? reg_pick() : 5'd0, result: $urandom};
        mem_fwd           = '{dest: fwd_on ? reg_pick() : 5'd0, result: $urandom};
        ws_to_rf_bus      = '{we: 1'($urandom_range(1)), addr: reg_pick(), data: $urandom};
        // writeback forwards what it writes this cycle
        wb_fwd.dest       = (fwd_on && ws_to_rf_bus.we) ? ws_to_rf_bus.addr : 5'd0;
        wb_fwd.result     = ws_to_rf_bus.data;
    endtask

    task automatic run_random(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            drive_random();
            @(negedge clk);
            check_cycle();
        end
    endtask

    task automatic set_mix(input int fetch, input int hold, input int flsh, input int load,
                           input logic fwd, input logic br_only, input reg_addr_t mask);
        fetch_pct   = fetch;
        hold_pct    = hold;
        flush_pct   = flsh;
        load_pct    = load;
        fwd_on      = fwd;
        branch_only = br_only;
        reg_mask    = mask;
    endtask

    task automatic report_test(input string name);
        if (test_errors != 0)
            failed_tests++;
        $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAIL",
                 test_errors);
        test_errors = 0;
    endtask

    initial begin
        void'($urandom(32'h70610ca7));
        clk            = 1'b0;
        reset          = 1'b1;
        flush          = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b1;
        ws_to_rf_bus   = '0;
        exe_fwd        = '0;
        mem_fwd        = '0;
        wb_fwd         = '0;
        es_load_op     = 1'b0;
        m_valid        = 1'b0;
        foreach (m_rf[i])
            m_rf[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_cycle();
        // every register gets a known value first
        for (int i = 1; i < 32; i++) begin
            @(posedge clk);
            #1;
            ws_to_rf_bus = '{we: 1'b1, addr: reg_addr_t'(i), data: $urandom};
            @(negedge clk);
            check_cycle();
        end
        report_test("reset");
        set_mix(100, 0, 0, 0, 1'b0, 1'b0, 5'h1f);
        run_random(run_len);
        report_test("decode");
        set_mix(80, 0, 0, 0, 1'b0, 1'b0, 5'h07);
        run_random(run_len);
        report_test("regfile");
        set_mix(80, 10, 0, 30, 1'b1, 1'b0, 5'h07);
        run_random(run_len);
        report_test("forwarding");
        set_mix(90, 10, 0, 15, 1'b1, 1'b1, 5'h03);
        run_random(run_len);
        report_test("branch");
        set_mix(70, 50, 20, 20, 1'b1, 1'b0, 5'h1f);
        run_random(run_len);
        report_test("hold_flush");
        $display("6 tests, %0d failed, %0d checks, %0d errors", failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        failed_tests = 0;
        #(total_cycles * 4 * 2);
        $display("timeout: the test sequence did not complete in time");
        $display("Some tests failed");
        $finish;
    end

endmodule
